// File: rtl/boot_rom.hex
// One 16-bit word per line, ROM word address 0 to 15 in order
// Words 0-3 are the reset SSP and PC, the rest is a short LED loop
FF40
0800
FFFC
0008
4E71
4E71
207C
FFDC
0600
3010
1080
60FC
4E71
4E75
4AFC
FFFF

// File: flist.f
rtl/sys_pkg.sv
rtl/cpu_req_if.sv
rtl/bus_decode.sv
rtl/boot_rom.sv
rtl/stack_ram.sv
rtl/rand_gen.sv
rtl/led_port.sv
rtl/n4v_bus_sys.sv
verif/n4v_bus_sys_tb.sv

// File: Bender.yml
package:
  name: n4v_bus_sys

sources:
  - rtl/sys_pkg.sv
  - rtl/cpu_req_if.sv
  - rtl/bus_decode.sv
  - rtl/boot_rom.sv
  - rtl/stack_ram.sv
  - rtl/rand_gen.sv
  - rtl/led_port.sv
  - rtl/n4v_bus_sys.sv
  - target: simulation
    files:
      - verif/n4v_bus_sys_tb.sv

// File: verif/n4v_bus_sys_tb.sv
/* Plays the 68000, every input changes on the falling clock edge.
   Reads rtl/boot_rom.hex for its ROM model, so run from the project root. */
`timescale 1ns/1ns
`default_nettype none

module n4v_bus_sys_tb;

	localparam int             STACK_AW    = 10;
	localparam int             ROM_AW      = 4;
	localparam sys_pkg::word_t RAND_SEED   = 16'hACE1;
	localparam int             ACK_TIMEOUT = 16;
	localparam logic [7:0]     SW_VAL      = 8'h5A;

	// One processor access and what it should produce
	typedef struct {
		logic           wr;
		sys_pkg::addr_t addr;
		logic [1:0]     lanes;
		sys_pkg::word_t wdata;
		logic [2:0]     btn;
		logic           ack_exp;
		int             lat_exp;
		logic           rd_chk;
		sys_pkg::word_t rd_exp;
		logic [7:0]     led_exp;
	} op_t;

	logic           cpu_clk;
	logic           rst;
	logic           as_n;
	logic           uds_n;
	logic           lds_n;
	logic           r_w;
	sys_pkg::addr_t addr;
	sys_pkg::word_t data_in;
	sys_pkg::word_t data_out;
	logic           dtack_n;
	logic [7:0]     sw;
	logic           btn_d;
	logic           btn_r;
	logic           btn_l;
	logic [7:0]     led;

	// Reference models
	sys_pkg::word_t rom_model [0:2**ROM_AW-1];
	sys_pkg::word_t ram_model [0:2**STACK_AW-1];
	sys_pkg::word_t rand_model;
	logic [7:0]     led_model;
	logic [15:0]    stim_lfsr;

	op_t ops[$];
	int  value_errs;
	int  lat_errs;
	int  bus_errs;

	n4v_bus_sys #(
		.STACK_AW  (STACK_AW),
		.ROM_AW    (ROM_AW),
		.RAND_SEED (RAND_SEED)
	) n4v_bus_sys_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.as_n    (as_n),
		.uds_n   (uds_n),
		.lds_n   (lds_n),
		.r_w     (r_w),
		.addr_i  (addr),
		.data_i  (data_in),
		.data_o  (data_out),
		.dtack_n (dtack_n),
		.sw_i    (sw),
		.btn_d_i (btn_d),
		.btn_r_i (btn_r),
		.btn_l_i (btn_l),
		.led_o   (led)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #5 cpu_clk = ~cpu_clk;
	end

	// ====================
	// Models and stimulus helpers

	// Stimulus source, x^16+x^15+x^13+x^4+1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// Feedback is the parity of every tapped state bit
	function automatic sys_pkg::word_t rand_next(input sys_pkg::word_t s);
		logic fb;
		fb = 1'b0;
		for (int k = 0; k < 16; k++) begin
			if (sys_pkg::RAND_TAPS[k])
				fb = fb ^ s[k];
		end
		return {s[14:0], fb};
	endfunction

	// Down beats right beats left
	function automatic logic [7:0] led_expect(input sys_pkg::addr_t a, input logic [2:0] btn);
		if (btn[2])
			return a[23:16];
		if (btn[1])
			return a[15:8];
		if (btn[0])
			return a[7:0];
		return led_model;
	endfunction

	task automatic push_op(input logic wr, input sys_pkg::addr_t a, input logic [1:0] lanes,
			input sys_pkg::word_t wd, input logic [2:0] btn, input logic ack_exp,
			input int lat_exp, input logic rd_chk, input sys_pkg::word_t rd_exp);
		op_t op;
		op.wr      = wr;
		op.addr    = a;
		op.lanes   = lanes;
		op.wdata   = wd;
		op.btn     = btn;
		op.ack_exp = ack_exp;
		op.lat_exp = lat_exp;
		op.rd_chk  = rd_chk;
		op.rd_exp  = rd_exp;
		op.led_exp = led_expect(a, btn);
		ops.push_back(op);
	endtask

	task automatic add_rand_reads(input int n);
		for (int i = 0; i < n; i++) begin
			push_op(0, {sys_pkg::RAND_ADDR, 4'h0}, 2'b11, '0, 3'b000, 1, 1, 1, rand_model);
			rand_model = rand_next(rand_model);
		end
	endtask

	// Table is built in run order, so the models track the DUT
	task automatic build_table();
		sys_pkg::addr_t a;
		sys_pkg::addr_t stack_addrs[$];
		sys_pkg::word_t wd;
		logic [1:0]     lanes;
		for (int i = 0; i < 4; i++)
			push_op(0, 32'(2 * i), 2'b11, '0, 3'b000, 1, 1, 1, rom_model[i]);
		for (int i = 0; i < 2**ROM_AW; i++)
			push_op(0, 32'hFFFC0000 + 32'(2 * i), 2'b11, '0, 3'b000, 1, 1, 1, rom_model[i]);
		// Full words first, so partial writes never leave X lanes
		for (int i = 0; i < 8; i++) begin
			a = {sys_pkg::STACK_BASE, 20'(rand_bits(19) << 1)};
			wd = 16'(rand_bits(16));
			ram_model[a[STACK_AW:1]] = wd;
			stack_addrs.push_back(a);
			push_op(1, a, 2'b11, wd, 3'b000, 1, 3, 0, '0);
		end
		foreach (stack_addrs[i]) begin
			a = stack_addrs[i];
			lanes = rand_bits(1) ? 2'b10 : 2'b01;
			wd = 16'(rand_bits(16));
			if (lanes[1])
				ram_model[a[STACK_AW:1]][15:8] = wd[15:8];
			if (lanes[0])
				ram_model[a[STACK_AW:1]][7:0] = wd[7:0];
			push_op(1, a, lanes, wd, 3'b000, 1, 3, 0, '0);
		end
		foreach (stack_addrs[i]) begin
			a = stack_addrs[i];
			push_op(0, a, 2'b11, '0, (i == 0) ? 3'b100 : 3'b000, 1, 3, 1,
				ram_model[a[STACK_AW:1]]);
		end
		add_rand_reads(4);
		wd = 16'(rand_bits(16));
		push_op(1, {sys_pkg::RAND_ADDR, 4'h0}, 2'b11, wd, 3'b000, 1, 1, 0, '0);
		rand_model = (wd == '0) ? RAND_SEED : wd;
		add_rand_reads(2);
		// A zero write reloads the seed
		push_op(1, {sys_pkg::RAND_ADDR, 4'h0}, 2'b11, '0, 3'b000, 1, 1, 0, '0);
		rand_model = RAND_SEED;
		add_rand_reads(2);
		a = {sys_pkg::LED_ADDR, 4'h0};
		led_model = 8'hC3;
		push_op(1, a, 2'b11, 16'h00C3, 3'b000, 1, 1, 0, '0);
		push_op(1, a, 2'b10, 16'h7E00, 3'b000, 1, 1, 0, '0);
		push_op(0, a, 2'b11, '0, 3'b000, 1, 1, 1, {SW_VAL, SW_VAL});
		push_op(0, a | 32'hA, 2'b11, '0, 3'b111, 1, 1, 1, {SW_VAL, SW_VAL});
		push_op(0, a | 32'hA, 2'b11, '0, 3'b011, 1, 1, 1, {SW_VAL, SW_VAL});
		push_op(0, a | 32'hA, 2'b11, '0, 3'b001, 1, 1, 1, {SW_VAL, SW_VAL});
		push_op(0, 32'hFFFC001E, 2'b11, '0, 3'b001, 1, 1, 1, rom_model[15]);
		// Unmapped hole, then a normal access behind it
		push_op(0, 32'h10000000, 2'b11, '0, 3'b000, 0, 0, 0, '0);
		push_op(0, 32'hFFFC0002, 2'b11, '0, 3'b000, 1, 1, 1, rom_model[1]);
	endtask

	// ====================
	// Bus cycle and compare tasks

	task automatic bus_access(input op_t op, output sys_pkg::word_t rd,
			output logic [7:0] led_seen, output int cycles, output logic acked);
		acked = 1'b0;
		cycles = 0;
		rd = '0;
		led_seen = '0;
		@(negedge cpu_clk);
		addr = op.addr;
		data_in = op.wr ? op.wdata : '0;
		r_w = ~op.wr;
		uds_n = ~op.lanes[1];
		lds_n = ~op.lanes[0];
		as_n = 1'b0;
		{btn_d, btn_r, btn_l} = op.btn;
		while (!acked && cycles < ACK_TIMEOUT) begin
			@(negedge cpu_clk);
			cycles++;
			if (!dtack_n) begin
				acked = 1'b1;
				rd = data_out;
				led_seen = led;
			end
		end
		// Strobes drop on the same falling edge that saw dtack
		as_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		r_w = 1'b1;
		{btn_d, btn_r, btn_l} = 3'b000;
	endtask

	task automatic check_word(input string name, input sys_pkg::word_t got,
			input sys_pkg::word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
			value_errs++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
			value_errs++;
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
			lat_errs++;
		end
	endtask

	// ====================
	// Main sequence
	initial begin
		sys_pkg::word_t rd;
		logic [7:0]     led_seen;
		int             cycles;
		logic           acked;
		rst = 1'b1;
		as_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		r_w = 1'b1;
		addr = '0;
		data_in = '0;
		sw = SW_VAL;
		btn_d = 1'b0;
		btn_r = 1'b0;
		btn_l = 1'b0;
		value_errs = 0;
		lat_errs = 0;
		bus_errs = 0;
		stim_lfsr = 16'd4728;
		rand_model = RAND_SEED;
		led_model = 8'h00;
		$readmemh("rtl/boot_rom.hex", rom_model);
		build_table();
		repeat (2) @(negedge cpu_clk);
		rst = 1'b0;
		foreach (ops[i]) begin
			bus_access(ops[i], rd, led_seen, cycles, acked);
			if (ops[i].ack_exp && !acked) begin
				$display("Access %0d to %h: no acknowledge arrived within %0d cycles",
					i, ops[i].addr, ACK_TIMEOUT);
				bus_errs++;
			end else if (!ops[i].ack_exp && acked) begin
				$display("Access %0d to unmapped %h was acknowledged", i, ops[i].addr);
				bus_errs++;
			end else if (acked) begin
				check_latency("dtack_n latency", cycles, ops[i].lat_exp);
				if (ops[i].rd_chk)
					check_word("data_o", rd, ops[i].rd_exp);
				check_byte("led_o", led_seen, ops[i].led_exp);
			end
		end
		$display("Summary: %0d accesses, %0d value mismatches, %0d latency mismatches, %0d bus failures",
			ops.size(), value_errs, lat_errs, bus_errs);
		if (value_errs + lat_errs + bus_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/n4v_bus_sys.sv
/* Processor pins are active-low 68000 strobes, data is split into in and out.
   No register on the dtack path, latency is set by each slave. */
`timescale 1ns/1ns
`default_nettype none

module n4v_bus_sys #(
	parameter int             STACK_AW  = 10,
	parameter int             ROM_AW    = 4,
	parameter sys_pkg::word_t RAND_SEED = 16'hACE1
) (
	input  wire logic       cpu_clk,
	input  wire logic       rst,
	input  wire logic       as_n,
	input  wire logic       uds_n,
	input  wire logic       lds_n,
	input  wire logic       r_w,
	input  sys_pkg::addr_t  addr_i,
	input  sys_pkg::word_t  data_i,
	output sys_pkg::word_t  data_o,
	output logic            dtack_n,
	input  wire logic [7:0] sw_i,
	input  wire logic       btn_d_i,
	input  wire logic       btn_r_i,
	input  wire logic       btn_l_i,
	output logic [7:0]      led_o
);

	cpu_req_if req ();

	logic cs_boot, cs_stack, cs_rand, cs_led;
	logic ack_boot, ack_stack, ack_rand, ack_led;
	sys_pkg::word_t rdata_boot, rdata_stack, rdata_rand, rdata_led;

	// ====================
	// Decoder
	bus_decode bus_decode_inst (
		.cpu_clk       (cpu_clk),
		.rst           (rst),
		.as_n          (as_n),
		.uds_n         (uds_n),
		.lds_n         (lds_n),
		.r_w           (r_w),
		.addr_i        (addr_i),
		.data_i        (data_i),
		.ack_boot_i    (ack_boot),
		.ack_stack_i   (ack_stack),
		.ack_rand_i    (ack_rand),
		.ack_led_i     (ack_led),
		.rdata_boot_i  (rdata_boot),
		.rdata_stack_i (rdata_stack),
		.rdata_rand_i  (rdata_rand),
		.rdata_led_i   (rdata_led),
		.req           (req.master),
		.cs_boot_o     (cs_boot),
		.cs_stack_o    (cs_stack),
		.cs_rand_o     (cs_rand),
		.cs_led_o      (cs_led),
		.data_o        (data_o),
		.dtack_n_o     (dtack_n)
	);

	// ====================
	// Slaves
	boot_rom #(.ROM_AW(ROM_AW)) boot_rom_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_boot),
		.req     (req.slave),
		.ack_o   (ack_boot),
		.rdata_o (rdata_boot)
	);

	stack_ram #(.STACK_AW(STACK_AW)) stack_ram_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_stack),
		.req     (req.slave),
		.ack_o   (ack_stack),
		.rdata_o (rdata_stack)
	);

	rand_gen #(.RAND_SEED(RAND_SEED)) rand_gen_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_rand),
		.req     (req.slave),
		.ack_o   (ack_rand),
		.rdata_o (rdata_rand)
	);

	led_port led_port_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_led),
		.req     (req.slave),
		.ack_o   (ack_led),
		.rdata_o (rdata_led),
		.sw_i    (sw_i),
		.btn_d_i (btn_d_i),
		.btn_r_i (btn_r_i),
		.btn_l_i (btn_l_i),
		.led_o   (led_o)
	);

endmodule

`default_nettype wire

// File: rtl/led_port.sv
/* Buttons are expected clean, there is no debouncing here.
   Only the low byte of a write reaches the LEDs. */
`timescale 1ns/1ns
`default_nettype none

module led_port (
	input  wire logic       cpu_clk,
	input  wire logic       rst,
	input  wire logic       cs_i,
	cpu_req_if.slave        req,
	output logic            ack_o,
	output sys_pkg::word_t  rdata_o,
	input  wire logic [7:0] sw_i,
	input  wire logic       btn_d_i,
	input  wire logic       btn_r_i,
	input  wire logic       btn_l_i,
	output logic [7:0]      led_o
);

	logic [7:0] led_q;
	logic       take;

	assign take = cs_i & req.stb & ~ack_o;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			led_q <= '0;
		end else begin
			ack_o <= take;
			if (take && req.we && req.lbe)
				led_q <= req.wdata[7:0];
		end
	end

	// Switches on both byte lanes
	assign rdata_o = {sw_i, sw_i};

	// Button priority is down, right, left
	always_comb begin
		if (btn_d_i)
			led_o = req.addr[23:16];
		else if (btn_r_i)
			led_o = req.addr[15:8];
		else if (btn_l_i)
			led_o = req.addr[7:0];
		else
			led_o = led_q;
	end

endmodule

`default_nettype wire

// File: rtl/rand_gen.sv
/* RAND_SEED must be nonzero, a zero write loads the seed instead.
   Each read steps the sequence once, writes do not step it. */
`timescale 1ns/1ns
`default_nettype none

module rand_gen #(
	parameter sys_pkg::word_t RAND_SEED = 16'hACE1
) (
	input  wire logic       cpu_clk,
	input  wire logic       rst,
	input  wire logic       cs_i,
	cpu_req_if.slave        req,
	output logic            ack_o,
	output sys_pkg::word_t  rdata_o
);

	sys_pkg::word_t lfsr;
	logic           take;
	logic           fb;

	assign take = cs_i & req.stb & ~ack_o;
	// Fibonacci feedback from the tapped bits
	assign fb = ^(lfsr & sys_pkg::RAND_TAPS);

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			lfsr  <= RAND_SEED;
		end else begin
			ack_o <= take;
			if (take && req.we)
				lfsr <= (req.wdata == '0) ? RAND_SEED : req.wdata;
			else if (take)
				lfsr <= {lfsr[14:0], fb};
		end
	end

	// Value before the step goes back to the processor
	always_ff @(posedge cpu_clk) begin
		if (take)
			rdata_o <= lfsr;
	end

	lfsr_nonzero_a: assert property (@(posedge cpu_clk) disable iff (rst)
		lfsr != '0);

endmodule

`default_nettype wire

// File: rtl/stack_ram.sv
/* Fixed three-cycle wait state for reads and writes alike.
   Word index is address bits STACK_AW:1, the rest of the window aliases. */
`timescale 1ns/1ns
`default_nettype none

module stack_ram #(
	parameter int STACK_AW = 10
) (
	input  wire logic       cpu_clk,
	input  wire logic       rst,
	input  wire logic       cs_i,
	cpu_req_if.slave        req,
	output logic            ack_o,
	output sys_pkg::word_t  rdata_o
);

	sys_pkg::word_t mem [0:2**STACK_AW-1];
	logic [1:0]     wait_cnt;
	logic           busy;
	logic           fire;
	logic [STACK_AW-1:0] widx;

	assign busy = cs_i & req.stb & ~ack_o;
	// Third advance of the counter
	assign fire = busy & (wait_cnt == 2'd2);
	assign widx = req.addr[STACK_AW:1];

	// ====================
	// Wait-state counter
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			wait_cnt <= '0;
			ack_o    <= 1'b0;
		end else begin
			ack_o <= fire;
			if (fire || !busy)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 2'd1;
		end
	end

	// ====================
	// Storage, written per byte lane on the ack edge
	always_ff @(posedge cpu_clk) begin
		if (fire) begin
			if (req.we && req.ube)
				mem[widx][15:8] <= req.wdata[15:8];
			if (req.we && req.lbe)
				mem[widx][7:0] <= req.wdata[7:0];
			rdata_o <= mem[widx];
		end
	end

	// Ack only after select and strobe were held for three edges
	ack_has_stb_a: assert property (@(posedge cpu_clk) disable iff (rst)
		$rose(ack_o) |-> $past(cs_i & req.stb, 1) && $past(cs_i & req.stb, 2)
			&& $past(cs_i & req.stb, 3));

endmodule

`default_nettype wire

// File: rtl/boot_rom.sv
/* Contents come from rtl/boot_rom.hex, so simulate from the project root.
   Only address bits ROM_AW:1 are decoded, the window aliases above that. */
`timescale 1ns/1ns
`default_nettype none

module boot_rom #(
	parameter int ROM_AW = 4
) (
	input  wire logic       cpu_clk,
	input  wire logic       rst,
	input  wire logic       cs_i,
	cpu_req_if.slave        req,
	output logic            ack_o,
	output sys_pkg::word_t  rdata_o
);

	sys_pkg::word_t rom [0:2**ROM_AW-1];

	initial begin
		$readmemh("rtl/boot_rom.hex", rom);
	end

	// Single-cycle ack, drops by itself
	always_ff @(posedge cpu_clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= cs_i & req.stb & ~ack_o;
	end

	// Word captured on the ack edge
	always_ff @(posedge cpu_clk) begin
		if (cs_i & req.stb & ~ack_o)
			rdata_o <= rom[req.addr[ROM_AW:1]];
	end

endmodule

`default_nettype wire

// File: rtl/bus_decode.sv
/* Purely combinational decode, no register between strobes and dtack.
   Unmapped addresses select nothing and are never acknowledged. */
`timescale 1ns/1ns
`default_nettype none

module bus_decode (
	input  wire logic           cpu_clk,
	input  wire logic           rst,
	input  wire logic           as_n,
	input  wire logic           uds_n,
	input  wire logic           lds_n,
	input  wire logic           r_w,
	input  sys_pkg::addr_t      addr_i,
	input  sys_pkg::word_t      data_i,
	input  wire logic           ack_boot_i,
	input  wire logic           ack_stack_i,
	input  wire logic           ack_rand_i,
	input  wire logic           ack_led_i,
	input  sys_pkg::word_t      rdata_boot_i,
	input  sys_pkg::word_t      rdata_stack_i,
	input  sys_pkg::word_t      rdata_rand_i,
	input  sys_pkg::word_t      rdata_led_i,
	cpu_req_if.master           req,
	output logic                cs_boot_o,
	output logic                cs_stack_o,
	output logic                cs_rand_o,
	output logic                cs_led_o,
	output sys_pkg::word_t      data_o,
	output logic                dtack_n_o
);

	sys_pkg::cs_e cs;

	// ====================
	// Pin strobes to request
	assign req.stb   = ~as_n & ~(uds_n & lds_n);
	assign req.we    = ~r_w;
	assign req.ube   = ~uds_n;
	assign req.lbe   = ~lds_n;
	assign req.addr  = addr_i;
	assign req.wdata = data_i;

	// ====================
	// Address decode, ROM wins at the reset vectors
	always_comb begin
		if (addr_i[31:16] == sys_pkg::BOOT_BASE || addr_i[31:3] == '0)
			cs = sys_pkg::CS_BOOT;
		else if (addr_i[31:20] == sys_pkg::STACK_BASE)
			cs = sys_pkg::CS_STACK;
		else if (addr_i[31:4] == sys_pkg::RAND_ADDR)
			cs = sys_pkg::CS_RAND;
		else if (addr_i[31:4] == sys_pkg::LED_ADDR)
			cs = sys_pkg::CS_LED;
		else
			cs = sys_pkg::CS_NONE;
	end

	assign cs_boot_o  = (cs == sys_pkg::CS_BOOT);
	assign cs_stack_o = (cs == sys_pkg::CS_STACK);
	assign cs_rand_o  = (cs == sys_pkg::CS_RAND);
	assign cs_led_o   = (cs == sys_pkg::CS_LED);

	// Read data back to the processor
	always_comb begin
		case (cs)
			sys_pkg::CS_BOOT:  data_o = rdata_boot_i;
			sys_pkg::CS_STACK: data_o = rdata_stack_i;
			sys_pkg::CS_RAND:  data_o = rdata_rand_i;
			sys_pkg::CS_LED:   data_o = rdata_led_i;
			default:           data_o = '0;
		endcase
	end

	assign dtack_n_o = ~(ack_boot_i | ack_stack_i | ack_rand_i | ack_led_i);

	// Slaves must never answer together
	ack_onehot_a: assert property (@(posedge cpu_clk) disable iff (rst)
		$onehot0({ack_boot_i, ack_stack_i, ack_rand_i, ack_led_i}));

endmodule

`default_nettype wire

// File: rtl/cpu_req_if.sv
/* One processor request, already converted from the active-low 68000 strobes.
   Signals are valid only while stb is high. */
`timescale 1ns/1ns
`default_nettype none

interface cpu_req_if;

	logic            stb;
	logic            we;
	logic            ube;
	logic            lbe;
	sys_pkg::addr_t  addr;
	sys_pkg::word_t  wdata;

	// Driven by the decoder
	modport master (output stb, output we, output ube, output lbe,
		output addr, output wdata);

	// Seen by every slave
	modport slave (input stb, input we, input ube, input lbe,
		input addr, input wdata);

endinterface

`default_nettype wire

// File: rtl/sys_pkg.sv
/* Address map and shared types of the 68000-side peripheral bus.
   Window bases cover upper address bits only, so smaller slaves alias inside their window. */
`default_nettype none

package sys_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [15:0] word_t;

	// Slave picked by the address decoder
	typedef enum logic [2:0] {
		CS_NONE,
		CS_BOOT,
		CS_STACK,
		CS_RAND,
		CS_LED
	} cs_e;

	// ====================
	// Address map

	// Bits 31:16, the low vectors 0..7 also map here
	localparam logic [15:0] BOOT_BASE = 16'hFFFC;
	// Bits 31:20
	localparam logic [11:0] STACK_BASE = 12'hFF4;
	// Bits 31:4
	localparam logic [27:0] RAND_ADDR = 28'hFFDC0C0;
	localparam logic [27:0] LED_ADDR = 28'hFFDC060;

	// ====================
	// LFSR taps for x^16+x^14+x^13+x^11+1, shifted towards the MSB
	localparam word_t RAND_TAPS = 16'hB400;

endpackage

`default_nettype wire
